// ==== logic/axi_wr_macros.svh ====
`ifndef AXI_WR_MACROS_SVH
`define AXI_WR_MACROS_SVH

// AXI4 channel widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_STRB_W 8
`define AXI_ID_W 4
`define AXI_LEN_W 8

// Beats buffered ahead of a command, also the longest burst
`define WFIFO_DEPTH 16

// 64-bit words, byte range 0 to 2047
`define MEM_WORDS 256

`endif

// ==== logic/axi_wr_pkg.sv ====
package axi_wr_pkg;

	typedef enum logic [1:0] {
		W_IDLE,
		W_ADDR,
		W_DATA,
		W_RESP
	} w_state_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_EXOKAY = 2'd1,
		RESP_SLVERR = 2'd2,
		RESP_DECERR = 2'd3
	} axi_resp_e;

	// Encoded as AxSIZE
	typedef enum logic [2:0] {
		SIZE_1B = 3'd0,
		SIZE_2B = 3'd1,
		SIZE_4B = 3'd2,
		SIZE_8B = 3'd3
	} axi_size_e;

	typedef enum logic [1:0] {
		S_IDLE,
		S_DATA,
		S_RESP
	} slv_state_e;

endpackage

// ==== logic/cpu_wr_req.sv ====
`timescale 1ns/100ps
`include "axi_wr_macros.svh"

module cpu_wr_req import axi_wr_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   wdata_push_i,
	input  logic [`AXI_DATA_W-1:0] wdata_i,
	input  logic                   cmd_valid_i,
	input  logic [`AXI_ADDR_W-1:0] cmd_addr_i,
	input  logic [`AXI_LEN_W-1:0]  cmd_len_i,
	input  axi_size_e              cmd_size_i,
	input  logic [`AXI_ID_W-1:0]   cmd_id_i,
	input  logic                   beat_pop_i,
	input  logic                   wr_done_i,
	input  axi_resp_e              wr_resp_i,
	output logic                   busy_o,
	output logic                   done_o,
	output axi_resp_e              resp_o,
	output logic                   req_valid_o,
	output logic [`AXI_ADDR_W-1:0] req_addr_o,
	output logic [`AXI_LEN_W-1:0]  req_len_o,
	output axi_size_e              req_size_o,
	output logic [`AXI_ID_W-1:0]   req_id_o,
	output logic [`AXI_DATA_W-1:0] beat_data_o
);
	localparam int PTR_W = $clog2(`WFIFO_DEPTH);
	localparam int CNT_W = $clog2(`WFIFO_DEPTH + 1);

	logic [`AXI_DATA_W-1:0] fifo_mem [`WFIFO_DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [CNT_W-1:0]       fifo_cnt;

	assign beat_data_o = fifo_mem[rd_ptr]; // Head of queue

	always_ff @(posedge clk) begin
		if (wdata_push_i)
			fifo_mem[wr_ptr] <= wdata_i;
	end

	// Depth is a power of two, pointers wrap on their own
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end else begin
			if (wdata_push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (beat_pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wdata_push_i, beat_pop_i})
				2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
				2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
				default: fifo_cnt <= fifo_cnt;
			endcase
		end
	end

	// Command fields held for the whole transaction
	always_ff @(posedge clk) begin
		if (cmd_valid_i) begin
			req_addr_o <= cmd_addr_i;
			req_len_o  <= cmd_len_i;
			req_size_o <= cmd_size_i;
			req_id_o   <= cmd_id_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy_o      <= 1'b0;
			done_o      <= 1'b0;
			req_valid_o <= 1'b0;
			resp_o      <= RESP_OKAY;
		end else begin
			req_valid_o <= cmd_valid_i;
			done_o      <= wr_done_i;
			if (cmd_valid_i)
				busy_o <= 1'b1;
			else if (wr_done_i)
				busy_o <= 1'b0; // Falls as done_o rises
			if (wr_done_i)
				resp_o <= wr_resp_i;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
		wdata_push_i |-> fifo_cnt < CNT_W'(`WFIFO_DEPTH));

	a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
		beat_pop_i |-> fifo_cnt != '0);

	// Command must find exactly its beats waiting
	a_beats_match: assert property (@(posedge clk) disable iff (!reset_n)
		cmd_valid_i |-> (`AXI_LEN_W+1)'(fifo_cnt) == {1'b0, cmd_len_i} + 1'b1);

	a_idle_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
		busy_o |-> !cmd_valid_i && !wdata_push_i);

endmodule

// ==== logic/axi_wr_master.sv ====
`timescale 1ns/100ps
`include "axi_wr_macros.svh"

module axi_wr_master import axi_wr_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   req_valid_i,
	input  logic [`AXI_ADDR_W-1:0] req_addr_i,
	input  logic [`AXI_LEN_W-1:0]  req_len_i,
	input  axi_size_e              req_size_i,
	input  logic [`AXI_ID_W-1:0]   req_id_i,
	input  logic [`AXI_DATA_W-1:0] beat_data_i,
	input  logic                   awready_i,
	input  logic                   wready_i,
	input  logic                   bvalid_i,
	input  axi_resp_e              bresp_i,
	output logic                   beat_pop_o,
	output logic                   wr_done_o,
	output axi_resp_e              wr_resp_o,
	output logic                   awvalid_o,
	output logic [`AXI_ADDR_W-1:0] awaddr_o,
	output logic [`AXI_LEN_W-1:0]  awlen_o,
	output axi_size_e              awsize_o,
	output logic [`AXI_ID_W-1:0]   awid_o,
	output logic                   wvalid_o,
	output logic [`AXI_DATA_W-1:0] wdata_o,
	output logic [`AXI_STRB_W-1:0] wstrb_o,
	output logic                   wlast_o,
	output logic                   bready_o
);
	w_state_e               state;
	w_state_e               state_nxt;
	logic [`AXI_LEN_W-1:0]  beat_q;
	logic [`AXI_ADDR_W-1:0] beat_off;
	logic [`AXI_ADDR_W-1:0] beat_addr;
	logic [`AXI_STRB_W-1:0] size_mask;
	logic                   aw_hs;
	logic                   w_hs;
	logic                   b_hs;

	assign aw_hs = awvalid_o && awready_i;
	assign w_hs  = wvalid_o && wready_i;
	assign b_hs  = bready_o && bvalid_i;

	always_comb begin
		state_nxt = state;
		case (state)
			W_IDLE:
				if (req_valid_i)
					state_nxt = W_ADDR;
			W_ADDR:
				if (aw_hs)
					state_nxt = W_DATA;
			W_DATA:
				if (w_hs && wlast_o)
					state_nxt = W_RESP;
			W_RESP:
				if (b_hs)
					state_nxt = W_IDLE;
			default:
				state_nxt = W_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state     <= W_IDLE;
			beat_q    <= '0;
			wr_done_o <= 1'b0;
			wr_resp_o <= RESP_OKAY;
		end else begin
			state     <= state_nxt;
			wr_done_o <= b_hs;
			if (state == W_IDLE)
				beat_q <= '0;
			else if (w_hs)
				beat_q <= beat_q + 1'b1;
			if (b_hs)
				wr_resp_o <= bresp_i;
		end
	end

	// Byte address of the current beat
	assign beat_off  = {{(`AXI_ADDR_W-`AXI_LEN_W){1'b0}}, beat_q} << req_size_i;
	assign beat_addr = req_addr_i + beat_off;

	always_comb begin
		case (req_size_i)
			SIZE_1B: size_mask = `AXI_STRB_W'(8'h01);
			SIZE_2B: size_mask = `AXI_STRB_W'(8'h03);
			SIZE_4B: size_mask = `AXI_STRB_W'(8'h0f);
			default: size_mask = {`AXI_STRB_W{1'b1}};
		endcase
	end

	// INCR burst from the aligned word address
	assign awvalid_o = (state == W_ADDR);
	assign awaddr_o  = {req_addr_i[`AXI_ADDR_W-1:3], 3'b000};
	assign awlen_o   = req_len_i;
	assign awsize_o  = req_size_i;
	assign awid_o    = req_id_i;

	assign wvalid_o   = (state == W_DATA);
	assign wdata_o    = beat_data_i;
	assign wstrb_o    = size_mask << beat_addr[2:0];
	assign wlast_o    = wvalid_o && (beat_q == req_len_i);
	assign beat_pop_o = w_hs;

	assign bready_o = (state == W_RESP);

	a_aw_hold: assert property (@(posedge clk) disable iff (!reset_n)
		awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o) && $stable(awlen_o)
			&& $stable(awsize_o) && $stable(awid_o));

	// Data comes straight from the FIFO head
	a_w_hold: assert property (@(posedge clk) disable iff (!reset_n)
		wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wstrb_o)
			&& $stable(wlast_o));

	// No beat goes out past the one with wlast
	a_beat_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		wvalid_o |-> beat_q <= req_len_i);

endmodule

// ==== logic/axi_sram_slave.sv ====
`timescale 1ns/100ps
`include "axi_wr_macros.svh"

module axi_sram_slave import axi_wr_pkg::*; (
	input  logic                           clk,
	input  logic                           reset_n,
	input  logic                           awvalid_i,
	input  logic [`AXI_ADDR_W-1:0]         awaddr_i,
	input  logic [`AXI_LEN_W-1:0]          awlen_i,
	input  axi_size_e                      awsize_i,
	input  logic [`AXI_ID_W-1:0]           awid_i,
	input  logic                           wvalid_i,
	input  logic [`AXI_DATA_W-1:0]         wdata_i,
	input  logic [`AXI_STRB_W-1:0]         wstrb_i,
	input  logic                           wlast_i,
	input  logic                           bready_i,
	input  logic [$clog2(`MEM_WORDS)-1:0]  dbg_addr_i,
	output logic                           awready_o,
	output logic                           wready_o,
	output logic                           bvalid_o,
	output axi_resp_e                      bresp_o,
	output logic [`AXI_ID_W-1:0]           bid_o,
	output logic [`AXI_DATA_W-1:0]         dbg_data_o
);
	localparam int MEM_AW = $clog2(`MEM_WORDS);
	localparam int WA_W   = `AXI_ADDR_W - 3;

	slv_state_e             state;
	logic [`AXI_DATA_W-1:0] mem [`MEM_WORDS];
	logic [WA_W-1:0]        wa_q;
	logic [`AXI_LEN_W-1:0]  len_q;
	logic [`AXI_LEN_W-1:0]  beat_q;
	axi_size_e              size_q;
	logic                   err_q;
	logic [`AXI_ADDR_W:0]   last_byte;
	logic                   aw_oob;
	logic                   beat_oob;
	logic                   aw_hs;
	logic                   w_hs;
	logic                   b_hs;

	assign aw_hs = awvalid_i && awready_o;
	assign w_hs  = wvalid_i && wready_o;
	assign b_hs  = bvalid_o && bready_i;

	// Whole burst checked up front so an overrun writes nothing
	assign last_byte = {1'b0, awaddr_i}
		+ ((((`AXI_ADDR_W+1)'(awlen_i)) + 1'b1) << awsize_i) - 1'b1;
	assign aw_oob    = last_byte[`AXI_ADDR_W:3] >= (`AXI_ADDR_W-2)'(`MEM_WORDS);
	assign beat_oob  = wa_q >= WA_W'(`MEM_WORDS);

	assign wready_o = (state == S_DATA);
	assign bvalid_o = (state == S_RESP);
	assign bresp_o  = err_q ? RESP_SLVERR : RESP_OKAY;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state     <= S_IDLE;
			awready_o <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			awready_o <= (state == S_IDLE) && !aw_hs;
			case (state)
				S_IDLE:
					if (aw_hs)
						state <= S_DATA;
				S_DATA:
					if (w_hs && wlast_i)
						state <= S_RESP;
				S_RESP:
					if (b_hs)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
			if (aw_hs)
				err_q <= aw_oob;
			else if (w_hs && beat_oob)
				err_q <= 1'b1; // Sticky until next burst
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs) begin
			wa_q   <= awaddr_i[`AXI_ADDR_W-1:3];
			len_q  <= awlen_i;
			size_q <= awsize_i;
			bid_o  <= awid_i;
			beat_q <= '0;
		end else if (w_hs) begin
			beat_q <= beat_q + 1'b1;
			// Next word once the top lane is used
			if (wstrb_i[`AXI_STRB_W-1] || size_q == SIZE_8B)
				wa_q <= wa_q + 1'b1;
		end
	end

	initial begin
		for (int i = 0; i < `MEM_WORDS; i++)
			mem[i] = '0;
	end

	always @(posedge clk) begin
		if (w_hs && !err_q && !beat_oob) begin
			for (int i = 0; i < `AXI_STRB_W; i++) begin
				if (wstrb_i[i])
					mem[wa_q[MEM_AW-1:0]][8*i +: 8] <= wdata_i[8*i +: 8];
			end
		end
		dbg_data_o <= mem[dbg_addr_i];
	end

	a_wlast_on_len: assert property (@(posedge clk) disable iff (!reset_n)
		w_hs |-> (wlast_i == (beat_q == len_q)));

endmodule

// ==== logic/axi_wr_top.sv ====
`timescale 1ns/100ps
`include "axi_wr_macros.svh"

module axi_wr_top import axi_wr_pkg::*; (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          wdata_push_i,
	input  logic [`AXI_DATA_W-1:0]        wdata_i,
	input  logic                          cmd_valid_i,
	input  logic [`AXI_ADDR_W-1:0]        cmd_addr_i,
	input  logic [`AXI_LEN_W-1:0]         cmd_len_i,
	input  axi_size_e                     cmd_size_i,
	input  logic [`AXI_ID_W-1:0]          cmd_id_i,
	output logic                          busy_o,
	output logic                          done_o,
	output axi_resp_e                     resp_o,
	input  logic [$clog2(`MEM_WORDS)-1:0] dbg_addr_i,
	output logic [`AXI_DATA_W-1:0]        dbg_data_o
);
	// Request side
	logic                   req_valid;
	logic [`AXI_ADDR_W-1:0] req_addr;
	logic [`AXI_LEN_W-1:0]  req_len;
	axi_size_e              req_size;
	logic [`AXI_ID_W-1:0]   req_id;
	logic [`AXI_DATA_W-1:0] beat_data;
	logic                   beat_pop;
	logic                   wr_done;
	axi_resp_e              wr_resp;

	// AXI write channels
	logic                   awvalid;
	logic                   awready;
	logic [`AXI_ADDR_W-1:0] awaddr;
	logic [`AXI_LEN_W-1:0]  awlen;
	axi_size_e              awsize;
	logic [`AXI_ID_W-1:0]   awid;
	logic                   wvalid;
	logic                   wready;
	logic [`AXI_DATA_W-1:0] wdata;
	logic [`AXI_STRB_W-1:0] wstrb;
	logic                   wlast;
	logic                   bvalid;
	logic                   bready;
	axi_resp_e              bresp;

	cpu_wr_req req_i (
		.clk          (clk),
		.reset_n      (reset_n),
		.wdata_push_i (wdata_push_i),
		.wdata_i      (wdata_i),
		.cmd_valid_i  (cmd_valid_i),
		.cmd_addr_i   (cmd_addr_i),
		.cmd_len_i    (cmd_len_i),
		.cmd_size_i   (cmd_size_i),
		.cmd_id_i     (cmd_id_i),
		.beat_pop_i   (beat_pop),
		.wr_done_i    (wr_done),
		.wr_resp_i    (wr_resp),
		.busy_o       (busy_o),
		.done_o       (done_o),
		.resp_o       (resp_o),
		.req_valid_o  (req_valid),
		.req_addr_o   (req_addr),
		.req_len_o    (req_len),
		.req_size_o   (req_size),
		.req_id_o     (req_id),
		.beat_data_o  (beat_data)
	);

	axi_wr_master master_i (
		.clk         (clk),
		.reset_n     (reset_n),
		.req_valid_i (req_valid),
		.req_addr_i  (req_addr),
		.req_len_i   (req_len),
		.req_size_i  (req_size),
		.req_id_i    (req_id),
		.beat_data_i (beat_data),
		.awready_i   (awready),
		.wready_i    (wready),
		.bvalid_i    (bvalid),
		.bresp_i     (bresp),
		.beat_pop_o  (beat_pop),
		.wr_done_o   (wr_done),
		.wr_resp_o   (wr_resp),
		.awvalid_o   (awvalid),
		.awaddr_o    (awaddr),
		.awlen_o     (awlen),
		.awsize_o    (awsize),
		.awid_o      (awid),
		.wvalid_o    (wvalid),
		.wdata_o     (wdata),
		.wstrb_o     (wstrb),
		.wlast_o     (wlast),
		.bready_o    (bready)
	);

	// Single outstanding write, BID not needed upstream
	axi_sram_slave sram_i (
		.clk        (clk),
		.reset_n    (reset_n),
		.awvalid_i  (awvalid),
		.awaddr_i   (awaddr),
		.awlen_i    (awlen),
		.awsize_i   (awsize),
		.awid_i     (awid),
		.wvalid_i   (wvalid),
		.wdata_i    (wdata),
		.wstrb_i    (wstrb),
		.wlast_i    (wlast),
		.bready_i   (bready),
		.dbg_addr_i (dbg_addr_i),
		.awready_o  (awready),
		.wready_o   (wready),
		.bvalid_o   (bvalid),
		.bresp_o    (bresp),
		.bid_o      (),
		.dbg_data_o (dbg_data_o)
	);

endmodule

// ==== verification/axi_wr_tb.sv ====
`timescale 1ns/100ps
`include "axi_wr_macros.svh"

module axi_wr_tb import axi_wr_pkg::*; ();
	logic                          clk;
	logic                          reset_n;
	logic                          wdata_push_i;
	logic [`AXI_DATA_W-1:0]        wdata_i;
	logic                          cmd_valid_i;
	logic [`AXI_ADDR_W-1:0]        cmd_addr_i;
	logic [`AXI_LEN_W-1:0]         cmd_len_i;
	axi_size_e                     cmd_size_i;
	logic [`AXI_ID_W-1:0]          cmd_id_i;
	logic [$clog2(`MEM_WORDS)-1:0] dbg_addr_i;
	logic                          busy_o;
	logic                          done_o;
	axi_resp_e                     resp_o;
	logic [`AXI_DATA_W-1:0]        dbg_data_o;

	logic [7:0]             ref_mem [`MEM_WORDS*8]; // Byte view of the SRAM
	logic [`AXI_DATA_W-1:0] beats [`WFIFO_DEPTH];
	logic [15:0]            lfsr = 16'd79;
	string                  cur_test;
	int                     err_cnt;
	int                     test_cnt;
	int                     bad_tests;
	int                     errs_at_start;

	axi_wr_top dut_i (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [63:0] random_word();
		logic [63:0] w;
		w = '0;
		for (int i = 0; i < 64; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit
			w = {w[62:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic logic [7:0] lane_mask(axi_size_e size, logic [2:0] off);
		logic [15:0] m;
		m = ((16'd1 << (1 << size)) - 16'd1) << off;
		return m[7:0]; // Lanes past byte 7 drop out
	endfunction

	function automatic logic [63:0] ref_word(int w);
		logic [63:0] d;
		for (int i = 0; i < 8; i++)
			d[8*i +: 8] = ref_mem[8*w + i];
		return d;
	endfunction

	task automatic report_mismatch(string what, logic [63:0] exp, logic [63:0] act);
		err_cnt++;
		$display("[FAIL] %s: %s expected %h, actual %h", cur_test, what, exp, act);
	endtask

	task automatic report_error(string what);
		err_cnt++;
		$display("ERROR in %s: %s", cur_test, what);
	endtask

	task automatic abort_run(string what);
		$display("ERROR in %s: %s", cur_test, what);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic start_test(string name);
		cur_test = name;
		errs_at_start = err_cnt;
		test_cnt++;
	endtask

	task automatic finish_test();
		if (err_cnt == errs_at_start) begin
			$display("test %s: ok", cur_test);
		end else begin
			bad_tests++;
			$display("test %s: %0d errors", cur_test, err_cnt - errs_at_start);
		end
	endtask

	task automatic fill_beats(int n);
		for (int b = 0; b < n; b++)
			beats[b] = random_word();
	endtask

	// Push the beats, issue one command and follow it to done_o
	task automatic write_burst(logic [31:0] addr, int len, axi_size_e size);
		axi_resp_e   exp_resp;
		logic [31:0] a;
		logic [7:0]  strb;
		int          cycles;
		exp_resp = RESP_OKAY;
		for (int b = 0; b <= len; b++) begin
			a = addr + (b << size);
			if ((a >> 3) >= `MEM_WORDS)
				exp_resp = RESP_SLVERR;
		end
		for (int b = 0; b <= len; b++) begin
			wdata_push_i = 1'b1;
			wdata_i      = beats[b];
			next_cycle();
		end
		wdata_push_i = 1'b0;
		cmd_valid_i  = 1'b1;
		cmd_addr_i   = addr;
		cmd_len_i    = `AXI_LEN_W'(len);
		cmd_size_i   = size;
		cmd_id_i     = cmd_id_i + 1'b1;
		next_cycle();
		cmd_valid_i = 1'b0;
		assert (busy_o) else report_error("busy_o did not rise after the command");
		cycles = 0;
		do begin
			next_cycle();
			cycles++;
			if (cycles > 100)
				abort_run("no done_o pulse within 100 cycles of the command");
			assert (busy_o || done_o) else report_error("busy_o dropped before done_o");
		end while (!done_o);
		assert (cycles >= len + 5)
			else report_error($sformatf("done_o after %0d cycles, below %0d", cycles, len + 5));
		assert (!busy_o) else report_error("busy_o still high with done_o");
		assert (resp_o == exp_resp) else report_mismatch("resp_o", exp_resp, resp_o);
		if (exp_resp == RESP_OKAY) begin
			for (int b = 0; b <= len; b++) begin
				a    = addr + (b << size);
				strb = lane_mask(size, a[2:0]);
				for (int i = 0; i < 8; i++) begin
					if (strb[i])
						ref_mem[8*(a >> 3) + i] = beats[b][8*i +: 8];
				end
			end
		end
		repeat (3) begin
			next_cycle();
			assert (!done_o) else report_error("second done_o pulse for one command");
		end
	endtask

	task automatic compare_memory();
		for (int w = 0; w < `MEM_WORDS; w++) begin
			dbg_addr_i = $clog2(`MEM_WORDS)'(w);
			next_cycle();
			assert (dbg_data_o == ref_word(w))
				else report_mismatch($sformatf("word %0d", w), ref_word(w), dbg_data_o);
		end
	endtask

	a_done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		done_o |=> !done_o)
		else report_error("done_o high for two cycles in a row");

	// Busy ends only with the done pulse
	a_busy_falls_on_done: assert property (@(posedge clk) disable iff (!reset_n)
		$fell(busy_o) |-> done_o)
		else report_error("busy_o fell without done_o");

	initial begin
		reset_n      = 1'b0;
		wdata_push_i = 1'b0;
		wdata_i      = '0;
		cmd_valid_i  = 1'b0;
		cmd_addr_i   = '0;
		cmd_len_i    = '0;
		cmd_size_i   = SIZE_8B;
		cmd_id_i     = '0;
		dbg_addr_i   = '0;
		err_cnt      = 0;
		test_cnt     = 0;
		bad_tests    = 0;
		for (int i = 0; i < `MEM_WORDS*8; i++)
			ref_mem[i] = 8'h00;
		repeat (2) @(posedge clk);
		#2;
		reset_n = 1'b1;

		start_test("reset");
		repeat (4) begin
			next_cycle();
			assert (!busy_o && !done_o) else report_error("busy_o or done_o high after reset");
		end
		compare_memory();
		finish_test();

		start_test("single_8b");
		fill_beats(1);
		write_burst(32'h100, 0, SIZE_8B);
		compare_memory();
		finish_test();

		start_test("narrow_unaligned");
		fill_beats(2);
		write_burst(32'h200, 1, SIZE_8B); // Neighbors first
		fill_beats(1);
		write_burst(32'h203, 0, SIZE_1B);
		fill_beats(1);
		write_burst(32'h20d, 0, SIZE_2B);
		fill_beats(1);
		write_burst(32'h20a, 0, SIZE_4B);
		compare_memory();
		finish_test();

		start_test("incr_bursts");
		fill_beats(16);
		write_burst(32'h300, 15, SIZE_8B);
		fill_beats(4);
		write_burst(32'h404, 3, SIZE_4B);
		fill_beats(4);
		write_burst(32'h50c, 3, SIZE_2B);
		fill_beats(4);
		write_burst(32'h606, 3, SIZE_1B);
		compare_memory();
		finish_test();

		start_test("out_of_range");
		fill_beats(16);
		write_burst(32'h7c0, 15, SIZE_8B);
		fill_beats(4);
		write_burst(32'h7f8, 3, SIZE_4B); // Crosses the top by two beats
		compare_memory();
		finish_test();

		$display("%0d tests, %0d failed, %0d errors", test_cnt, bad_tests, err_cnt);
		if (err_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+logic
logic/axi_wr_pkg.sv
logic/cpu_wr_req.sv
logic/axi_wr_master.sv
logic/axi_sram_slave.sv
logic/axi_wr_top.sv
verification/axi_wr_tb.sv

// ==== Bender.yml ====
package:
  name: axi_wr

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/axi_wr_pkg.sv
      - logic/cpu_wr_req.sv
      - logic/axi_wr_master.sv
      - logic/axi_sram_slave.sv
      - logic/axi_wr_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/axi_wr_tb.sv
